/* Bender.yml */
package:
  name: gf_coproc

sources:
  - gf_pkg.sv
  - gf_mul.sv
  - gf_divider.sv
  - gf_op_ctrl.sv
  - gf_result_fifo.sv
  - gf_apb_regs.sv
  - gf_coproc.sv
  - target: test
    files:
      - tb_gf_coproc.sv

/* gf_apb_regs.sv */
module gf_apb_regs #(
	parameter int M = 8,
	parameter int FIFO_DEPTH = 4,
	localparam int CW = $clog2(FIFO_DEPTH + 1)
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [gf_pkg::APB_AW-1:0] paddr,
	input  logic [gf_pkg::APB_DW-1:0] pwdata,
	output logic [gf_pkg::APB_DW-1:0] prdata,
	output logic                      pready,
	output logic                      pslverr,
	output logic                      cmd_valid,
	output gf_pkg::op_e               cmd_op,
	output logic [M-1:0]              opa,
	output logic [M-1:0]              opb,
	input  logic                      busy,
	input  logic                      res_divz,
	input  logic [M-1:0]              rd_data,
	input  logic [CW-1:0]             fifo_count,
	input  logic                      fifo_empty,
	input  logic                      fifo_full,
	output logic                      rd_en
);
	localparam logic [CW-1:0] LAST_SLOT = CW'(FIFO_DEPTH - 1);

	logic access;
	logic wr_acc;
	logic rd_acc;
	logic op_legal;
	logic no_room;
	logic err;
	logic launch;
	logic launch_q;  // Fast result still on its way to the FIFO.
	logic divz;
	logic [gf_pkg::APB_DW-1:0] status;

	assign access = psel & penable;
	assign wr_acc = access & pwrite;
	assign rd_acc = access & ~pwrite;
	assign op_legal = (pwdata[2:0] <= gf_pkg::OP_DIV);

	// A pending result takes the last slot before the FIFO count shows it.
	assign no_room = fifo_full | ((cmd_valid | launch_q) & (fifo_count == LAST_SLOT));

	always_comb begin
		case (paddr)
			gf_pkg::ADDR_OPA,
			gf_pkg::ADDR_OPB:    err = 1'b0;
			gf_pkg::ADDR_CMD:    err = pwrite & (busy | cmd_valid | no_room | ~op_legal);
			gf_pkg::ADDR_STATUS: err = pwrite;  // Read only.
			gf_pkg::ADDR_RESULT: err = pwrite | fifo_empty;
			default:             err = 1'b1;
		endcase
	end

	assign pready = 1'b1;  // No wait states.
	assign pslverr = access & err;
	assign launch = wr_acc & ~err & (paddr == gf_pkg::ADDR_CMD);
	assign rd_en = rd_acc & ~err & (paddr == gf_pkg::ADDR_RESULT);

	always_ff @(posedge clk) begin
		if (reset) begin
			opa <= '0;
			opb <= '0;
			cmd_valid <= 1'b0;
			cmd_op <= gf_pkg::OP_ADD;
			launch_q <= 1'b0;
			divz <= 1'b0;
		end else begin
			cmd_valid <= launch;
			launch_q <= cmd_valid;
			if (launch) begin
				cmd_op <= gf_pkg::op_e'(pwdata[2:0]);
			end
			if (wr_acc & (paddr == gf_pkg::ADDR_OPA)) begin
				opa <= pwdata[M-1:0];  // Upper bits dropped.
			end
			if (wr_acc & (paddr == gf_pkg::ADDR_OPB)) begin
				opb <= pwdata[M-1:0];
			end
			if (res_divz) begin
				divz <= 1'b1;  // Set wins over a clearing read.
			end else if (rd_acc & (paddr == gf_pkg::ADDR_STATUS)) begin
				divz <= 1'b0;
			end
		end
	end

	always_comb begin
		status = '0;
		status[gf_pkg::STAT_BUSY] = busy;
		status[gf_pkg::STAT_EMPTY] = fifo_empty;
		status[gf_pkg::STAT_FULL] = fifo_full;
		status[gf_pkg::STAT_DIVZ] = divz;
		status[gf_pkg::STAT_COUNT +: CW] = fifo_count;
	end

	always_comb begin
		prdata = '0;
		case (paddr)
			gf_pkg::ADDR_OPA:    prdata[M-1:0] = opa;
			gf_pkg::ADDR_OPB:    prdata[M-1:0] = opb;
			gf_pkg::ADDR_CMD:    prdata[2:0] = cmd_op;  // Last launched opcode.
			gf_pkg::ADDR_STATUS: prdata = status;
			gf_pkg::ADDR_RESULT: prdata[M-1:0] = rd_data;
			default:             prdata = '0;
		endcase
	end

endmodule

/* gf_coproc.f */
gf_pkg.sv
gf_mul.sv
gf_divider.sv
gf_op_ctrl.sv
gf_result_fifo.sv
gf_apb_regs.sv
gf_coproc.sv
tb_gf_coproc.sv

/* gf_coproc.sv */
module gf_coproc #(
	parameter int M = 8,
	parameter int FIFO_DEPTH = 4
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [gf_pkg::APB_AW-1:0] paddr,
	input  logic [gf_pkg::APB_DW-1:0] pwdata,
	output logic [gf_pkg::APB_DW-1:0] prdata,
	output logic                      pready,
	output logic                      pslverr
);
	localparam int CW = $clog2(FIFO_DEPTH + 1);

	logic cmd_valid;
	gf_pkg::op_e cmd_op;
	logic [M-1:0] opa;
	logic [M-1:0] opb;
	logic busy;
	logic res_valid;
	logic [M-1:0] res_data;
	logic res_divz;
	logic [M-1:0] rd_data;
	logic [CW-1:0] fifo_count;
	logic fifo_empty;
	logic fifo_full;
	logic rd_en;

	gf_apb_regs #(
		.M(M),
		.FIFO_DEPTH(FIFO_DEPTH)
	) i_regs (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.cmd_valid(cmd_valid),
		.cmd_op(cmd_op),
		.opa(opa),
		.opb(opb),
		.busy(busy),
		.res_divz(res_divz),
		.rd_data(rd_data),
		.fifo_count(fifo_count),
		.fifo_empty(fifo_empty),
		.fifo_full(fifo_full),
		.rd_en(rd_en)
	);

	gf_op_ctrl #(
		.M(M)
	) i_ctrl (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_op(cmd_op),
		.opa(opa),
		.opb(opb),
		.busy(busy),
		.res_valid(res_valid),
		.res_data(res_data),
		.res_divz(res_divz)
	);

	gf_result_fifo #(
		.M(M),
		.FIFO_DEPTH(FIFO_DEPTH)
	) i_fifo (
		.clk(clk),
		.reset(reset),
		.wr_en(res_valid),
		.wr_data(res_data),
		.rd_en(rd_en),
		.rd_data(rd_data),
		.count(fifo_count),
		.empty(fifo_empty),
		.full(fifo_full)
	);

endmodule

/* gf_divider.sv */
module gf_divider #(
	parameter int M = 8
) (
	input  logic         clk,
	input  logic         reset,
	input  logic         start,
	input  logic [M-1:0] numer,
	input  logic [M-1:0] denom,
	output logic [M-1:0] quot,
	output logic         done
);
	localparam int CW = $clog2(M);
	localparam logic [CW-1:0] LAST_STEP = CW'(M - 2);

	logic [M-1:0] power;     // denom^(2^k) for the current step.
	logic [M-1:0] acc;       // Running product, starts at numer.
	logic [M-1:0] sq_in;
	logic [M-1:0] sq_out;
	logic [M-1:0] acc_next;
	logic [CW-1:0] step;
	logic running;

	// On start the squarer sees denom, so power begins at denom^2.
	assign sq_in = start ? denom : power;

	gf_mul #(
		.M(M)
	) i_square (
		.a(sq_in),
		.b(sq_in),
		.p(sq_out)
	);

	gf_mul #(
		.M(M)
	) i_accum (
		.a(acc),
		.b(power),
		.p(acc_next)
	);

	// M-1 multiply steps follow the load, so done lands M cycles after start.
	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			step <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				running <= 1'b1;
				step <= '0;
			end else if (running) begin
				step <= step + 1'b1;
				if (step == LAST_STEP) begin
					running <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			power <= sq_out;
			acc <= numer;
		end else if (running) begin
			power <= sq_out;
			acc <= acc_next;
		end
	end

	assign quot = acc;  // A zero denominator leaves zero here.

endmodule

/* gf_mul.sv */
module gf_mul #(
	parameter int M = 8
) (
	input  logic [M-1:0] a,
	input  logic [M-1:0] b,
	output logic [M-1:0] p
);
	localparam logic [15:0] POLY_FULL = gf_pkg::gf_poly(M);
	localparam logic [M-1:0] POLY = POLY_FULL[M-1:0];

	// a * alpha^i for every i, each one derived from the previous copy.
	logic [M-1:0] shifted [M];

	assign shifted[0] = a;

	genvar i;
	generate
		for (i = 1; i < M; i++) begin : g_alpha
			assign shifted[i] = {shifted[i-1][M-2:0], 1'b0} ^
				(POLY & {M{shifted[i-1][M-1]}});  // Reduce when the top bit falls out.
		end
	endgenerate

	// Bits of b pick which copies get summed.
	always_comb begin
		p = '0;
		for (int j = 0; j < M; j++) begin
			if (b[j]) begin
				p = p ^ shifted[j];
			end
		end
	end

endmodule

/* gf_op_ctrl.sv */
module gf_op_ctrl #(
	parameter int M = 8
) (
	input  logic         clk,
	input  logic         reset,
	input  logic         cmd_valid,
	input  gf_pkg::op_e  cmd_op,
	input  logic [M-1:0] opa,
	input  logic [M-1:0] opb,
	output logic         busy,
	output logic         res_valid,
	output logic [M-1:0] res_data,
	output logic         res_divz
);
	logic [M-1:0] mul_b;
	logic [M-1:0] mul_p;
	logic [M-1:0] div_numer;
	logic [M-1:0] div_denom;
	logic [M-1:0] quot;
	logic [M-1:0] fast_data;
	logic fast_op;
	logic slow_op;
	logic div_start;
	logic div_done;
	logic fast_valid;
	logic divz_pend;

	always_comb begin
		fast_op = 1'b0;
		slow_op = 1'b0;
		mul_b = opb;
		div_numer = opa;
		div_denom = opb;
		case (cmd_op)
			gf_pkg::OP_ADD, gf_pkg::OP_MUL: fast_op = 1'b1;
			gf_pkg::OP_SQR: begin
				fast_op = 1'b1;
				mul_b = opa;  // Squaring reuses the multiplier.
			end
			gf_pkg::OP_INV: begin
				slow_op = 1'b1;
				div_numer = {{(M-1){1'b0}}, 1'b1};
				div_denom = opa;
			end
			gf_pkg::OP_DIV: slow_op = 1'b1;
			default: fast_op = 1'b0;
		endcase
	end

	assign div_start = cmd_valid & slow_op;

	gf_mul #(
		.M(M)
	) i_mul (
		.a(opa),
		.b(mul_b),
		.p(mul_p)
	);

	gf_divider #(
		.M(M)
	) i_divider (
		.clk(clk),
		.reset(reset),
		.start(div_start),
		.numer(div_numer),
		.denom(div_denom),
		.quot(quot),
		.done(div_done)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			fast_valid <= 1'b0;
			busy <= 1'b0;
			divz_pend <= 1'b0;
		end else begin
			fast_valid <= cmd_valid & fast_op;
			if (div_start) begin
				busy <= 1'b1;
				divz_pend <= (div_denom == '0);
			end else if (div_done) begin
				busy <= 1'b0;  // Low from the cycle after the result.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_valid & fast_op) begin
			fast_data <= (cmd_op == gf_pkg::OP_ADD) ? (opa ^ opb) : mul_p;
		end
	end

	// Only one source can be active, the register block never overlaps them.
	assign res_valid = fast_valid | div_done;
	assign res_data = div_done ? quot : fast_data;
	assign res_divz = div_done & divz_pend;

endmodule

/* gf_pkg.sv */
package gf_pkg;

	localparam int APB_AW = 5;
	localparam int APB_DW = 32;

	// Opcodes 5 to 7 are illegal and get rejected at the APB side.
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_MUL = 3'd1,
		OP_SQR = 3'd2,
		OP_INV = 3'd3,
		OP_DIV = 3'd4
	} op_e;

	localparam logic [APB_AW-1:0] ADDR_OPA    = 5'h00;
	localparam logic [APB_AW-1:0] ADDR_OPB    = 5'h04;
	localparam logic [APB_AW-1:0] ADDR_CMD    = 5'h08;
	localparam logic [APB_AW-1:0] ADDR_STATUS = 5'h0C;
	localparam logic [APB_AW-1:0] ADDR_RESULT = 5'h10;

	localparam int STAT_BUSY  = 0;
	localparam int STAT_EMPTY = 1;
	localparam int STAT_FULL  = 2;
	localparam int STAT_DIVZ  = 3;  // Sticky, cleared by a STATUS read.
	localparam int STAT_COUNT = 8;  // Lowest bit of the FIFO fill count.
	localparam int STAT_COUNT_W = 5;

	// Primitive polynomial of GF(2^m), without the x^m term.
	function automatic logic [15:0] gf_poly(input int m);
		logic [15:0] poly;
		case (m)
			3:       poly = 16'h0003;  // x^3+x+1.
			4:       poly = 16'h0003;
			5:       poly = 16'h0005;
			6:       poly = 16'h0003;
			7:       poly = 16'h0003;
			8:       poly = 16'h001d;  // x^8+x^4+x^3+x^2+1.
			9:       poly = 16'h0011;
			10:      poly = 16'h0009;
			11:      poly = 16'h0005;
			12:      poly = 16'h0053;
			13:      poly = 16'h001b;
			14:      poly = 16'h0443;
			15:      poly = 16'h0003;
			16:      poly = 16'h100b;
			default: poly = 16'h0000;  // Width not supported.
		endcase
		return poly;
	endfunction

endpackage

/* gf_result_fifo.sv */
module gf_result_fifo #(
	parameter int M = 8,
	parameter int FIFO_DEPTH = 4,
	localparam int CW = $clog2(FIFO_DEPTH + 1)
) (
	input  logic          clk,
	input  logic          reset,
	input  logic          wr_en,
	input  logic [M-1:0]  wr_data,
	input  logic          rd_en,
	output logic [M-1:0]  rd_data,
	output logic [CW-1:0] count,
	output logic          empty,
	output logic          full
);
	localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam logic [AW-1:0] LAST_PTR = AW'(FIFO_DEPTH - 1);

	logic [M-1:0] mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic push;
	logic pop;

	assign push = wr_en & ~full;
	assign pop = rd_en & ~empty;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;  // Depth need not be 2^n.
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign rd_data = mem[rd_ptr];  // Head of queue.
	assign empty = (count == '0);
	assign full = (count == CW'(FIFO_DEPTH));

endmodule

/* tb_gf_coproc.sv */
module tb_gf_coproc;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int M = 8;
	localparam int FIFO_DEPTH = 4;
	localparam int POLL_LIMIT = 200;  // Cycles per STATUS poll loop.
	localparam int CNT_W = gf_pkg::STAT_COUNT_W;

	typedef struct packed {
		logic [2:0]   op;
		logic [M-1:0] a;
		logic [M-1:0] b;
		logic [M-1:0] res;
		logic         err;
		logic         divz;
	} entry_t;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [gf_pkg::APB_AW-1:0] paddr;
	logic [gf_pkg::APB_DW-1:0] pwdata;
	logic [gf_pkg::APB_DW-1:0] prdata;
	logic pready;
	logic pslverr;

	entry_t table_q [$];
	int seed = 32'hb3e0;

	gf_coproc #(
		.M(M),
		.FIFO_DEPTH(FIFO_DEPTH)
	) i_gf_coproc (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input logic [M-1:0] exp,
			input logic [M-1:0] act);
		if (act !== exp) begin
			stop_with_error($sformatf("FAIL %0t %s expected 0x%h got 0x%h", $time, name, exp, act));
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			stop_with_error($sformatf("FAIL %0t %s expected %b got %b", $time, name, exp, act));
		end
	endtask

	task automatic check_count(input string name, input logic [CNT_W-1:0] exp,
			input logic [CNT_W-1:0] act);
		if (act !== exp) begin
			stop_with_error($sformatf("FAIL %0t %s expected %0d got %0d", $time, name, exp, act));
		end
	endtask

	// Carry-less product, then reduction from the top bit down.
	function automatic logic [M-1:0] gf_mul_ref(input logic [M-1:0] a, input logic [M-1:0] b);
		logic [2*M-2:0] prod;
		logic [15:0] poly;
		logic [M:0] poly_full;
		prod = '0;
		poly = gf_pkg::gf_poly(M);
		poly_full = {1'b1, poly[M-1:0]};
		for (int i = 0; i < M; i++) begin
			if (b[i]) begin
				prod = prod ^ ((2*M-1)'(a) << i);
			end
		end
		for (int k = 2*M-2; k >= M; k--) begin
			if (prod[k]) begin
				prod = prod ^ ((2*M-1)'(poly_full) << (k - M));
			end
		end
		return prod[M-1:0];
	endfunction

	function automatic logic [M-1:0] gf_inv_ref(input logic [M-1:0] a);
		for (int c = 1; c < (1 << M); c++) begin
			if (gf_mul_ref(a, M'(c)) == 1) begin
				return M'(c);
			end
		end
		return '0;  // Zero has no inverse.
	endfunction

	task automatic apb_access(input logic write, input logic [gf_pkg::APB_AW-1:0] addr,
			input logic [gf_pkg::APB_DW-1:0] wdata, output logic [gf_pkg::APB_DW-1:0] rdata,
			output logic err);
		@(posedge clk);
		psel <= 1'b1;  // Setup cycle.
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		rdata = prdata;  // Middle of the access cycle.
		err = pslverr;
		check_flag("pready", 1'b1, pready);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input logic [gf_pkg::APB_AW-1:0] addr,
			input logic [gf_pkg::APB_DW-1:0] data, output logic err);
		logic [gf_pkg::APB_DW-1:0] unused;
		apb_access(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [gf_pkg::APB_AW-1:0] addr,
			output logic [gf_pkg::APB_DW-1:0] data, output logic err);
		apb_access(1'b0, addr, '0, data, err);
	endtask

	task automatic write_expect_ok(input logic [gf_pkg::APB_AW-1:0] addr,
			input logic [gf_pkg::APB_DW-1:0] data);
		logic err;
		apb_write(addr, data, err);
		check_flag("pslverr on write", 1'b0, err);
	endtask

	// Polls until the FIFO holds target results and the engine is idle.
	task automatic wait_for_count(input logic [CNT_W-1:0] target, input logic fast_only,
			output logic [gf_pkg::APB_DW-1:0] status);
		logic err;
		int waited;
		waited = 0;
		apb_read(gf_pkg::ADDR_STATUS, status, err);
		while (status[gf_pkg::STAT_COUNT +: CNT_W] != target || status[gf_pkg::STAT_BUSY]) begin
			if (fast_only) begin
				check_flag("STATUS.busy", 1'b0, status[gf_pkg::STAT_BUSY]);
			end
			waited += 3;  // One STATUS read is three cycles.
			if (waited > POLL_LIMIT) begin
				stop_with_error("Coprocessor never finished the operation within the timeout.");
			end
			apb_read(gf_pkg::ADDR_STATUS, status, err);
		end
	endtask

	function automatic void add_entry(input logic [2:0] op, input logic [M-1:0] a,
			input logic [M-1:0] b, input logic [M-1:0] res, input logic err, input logic divz);
		table_q.push_back({op, a, b, res, err, divz});
	endfunction

	task automatic run_entry(input entry_t e);
		logic [gf_pkg::APB_DW-1:0] status;
		logic [gf_pkg::APB_DW-1:0] rdata;
		logic [M-1:0] denom;
		logic err;
		denom = (e.op == gf_pkg::OP_INV) ? e.a : e.b;
		write_expect_ok(gf_pkg::ADDR_OPA, 32'(e.a));
		write_expect_ok(gf_pkg::ADDR_OPB, 32'(e.b));
		apb_write(gf_pkg::ADDR_CMD, 32'(e.op), err);
		check_flag("pslverr on CMD", e.err, err);
		if (!e.err) begin
			wait_for_count(1, e.op <= gf_pkg::OP_SQR, status);
			check_flag("STATUS.divz", e.divz, status[gf_pkg::STAT_DIVZ]);
			apb_read(gf_pkg::ADDR_STATUS, status, err);
			check_flag("STATUS.divz after read", 1'b0, status[gf_pkg::STAT_DIVZ]);
			apb_read(gf_pkg::ADDR_RESULT, rdata, err);
			check_flag("pslverr on RESULT", 1'b0, err);
			check_data("RESULT", e.res, rdata[M-1:0]);
			if (e.op >= gf_pkg::OP_INV && denom != '0) begin
				check_data("RESULT times denominator", (e.op == gf_pkg::OP_INV) ? M'(1) : e.a,
					gf_mul_ref(rdata[M-1:0], denom));
			end
		end
	endtask

	initial begin
		logic [gf_pkg::APB_DW-1:0] status;
		logic [gf_pkg::APB_DW-1:0] rdata;
		logic [M-1:0] expect_q [$];
		logic [M-1:0] a;
		logic [M-1:0] b;
		logic [31:0] rnd;
		logic err;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		apb_read(gf_pkg::ADDR_STATUS, status, err);  // Idle state after reset.
		check_flag("STATUS.empty", 1'b1, status[gf_pkg::STAT_EMPTY]);
		check_flag("STATUS.busy", 1'b0, status[gf_pkg::STAT_BUSY]);
		check_count("STATUS.count", 0, status[gf_pkg::STAT_COUNT +: CNT_W]);
		apb_read(gf_pkg::ADDR_RESULT, rdata, err);
		check_flag("pslverr on empty RESULT", 1'b1, err);
		apb_read(5'h14, rdata, err);
		check_flag("pslverr on unmapped read", 1'b1, err);
		apb_write(5'h1c, 32'h5a, err);
		check_flag("pslverr on unmapped write", 1'b1, err);

		// Hand values for x^8+x^4+x^3+x^2+1.
		add_entry(gf_pkg::OP_ADD, 8'h53, 8'hca, 8'h99, 1'b0, 1'b0);
		add_entry(gf_pkg::OP_MUL, 8'h02, 8'h80, 8'h1d, 1'b0, 1'b0);
		add_entry(gf_pkg::OP_MUL, 8'h03, 8'h03, 8'h05, 1'b0, 1'b0);
		add_entry(gf_pkg::OP_SQR, 8'h80, 8'h00, 8'h13, 1'b0, 1'b0);
		add_entry(gf_pkg::OP_INV, 8'h02, 8'h00, 8'h8e, 1'b0, 1'b0);
		add_entry(gf_pkg::OP_INV, 8'h01, 8'h00, 8'h01, 1'b0, 1'b0);
		add_entry(gf_pkg::OP_DIV, 8'h1d, 8'h02, 8'h80, 1'b0, 1'b0);
		add_entry(gf_pkg::OP_DIV, 8'h05, 8'h03, 8'h03, 1'b0, 1'b0);
		add_entry(gf_pkg::OP_DIV, 8'h37, 8'h00, 8'h00, 1'b0, 1'b1);
		add_entry(gf_pkg::OP_INV, 8'h00, 8'h00, 8'h00, 1'b0, 1'b1);
		add_entry(3'd5, 8'h12, 8'h34, 8'h00, 1'b1, 1'b0);  // Illegal opcodes.
		add_entry(3'd7, 8'h12, 8'h34, 8'h00, 1'b1, 1'b0);
		for (int i = 0; i < 20; i++) begin
			rnd = $random(seed);
			a = rnd[M-1:0];
			b = rnd[M+7:8];
			if (i % 2 == 0) begin
				add_entry(gf_pkg::OP_MUL, a, b, gf_mul_ref(a, b), 1'b0, 1'b0);
			end else begin
				add_entry(gf_pkg::OP_DIV, a, b, gf_mul_ref(a, gf_inv_ref(b)), 1'b0, b == '0);
			end
		end
		foreach (table_q[i]) begin
			run_entry(table_q[i]);
		end

		for (int i = 0; i < FIFO_DEPTH; i++) begin
			a = M'(8'h35 + i * 8'h1b);
			b = M'(8'h91 - i * 8'h07);
			write_expect_ok(gf_pkg::ADDR_OPA, 32'(a));
			write_expect_ok(gf_pkg::ADDR_OPB, 32'(b));
			write_expect_ok(gf_pkg::ADDR_CMD, 32'(gf_pkg::OP_MUL));
			expect_q.push_back(gf_mul_ref(a, b));
		end
		wait_for_count(FIFO_DEPTH, 1'b1, status);
		check_flag("STATUS.full", 1'b1, status[gf_pkg::STAT_FULL]);
		apb_write(gf_pkg::ADDR_CMD, 32'(gf_pkg::OP_ADD), err);
		check_flag("pslverr on CMD with full FIFO", 1'b1, err);
		apb_read(gf_pkg::ADDR_STATUS, status, err);
		apb_read(gf_pkg::ADDR_STATUS, status, err);  // Past any late push.
		check_count("STATUS.count when full", FIFO_DEPTH, status[gf_pkg::STAT_COUNT +: CNT_W]);
		foreach (expect_q[i]) begin
			apb_read(gf_pkg::ADDR_RESULT, rdata, err);
			check_flag("pslverr on RESULT", 1'b0, err);
			check_data("RESULT in issue order", expect_q[i], rdata[M-1:0]);
		end

		write_expect_ok(gf_pkg::ADDR_OPA, 32'h1d);
		write_expect_ok(gf_pkg::ADDR_OPB, 32'h02);
		write_expect_ok(gf_pkg::ADDR_CMD, 32'(gf_pkg::OP_DIV));
		apb_write(gf_pkg::ADDR_CMD, 32'(gf_pkg::OP_MUL), err);
		check_flag("pslverr on CMD while busy", 1'b1, err);
		wait_for_count(1, 1'b0, status);
		apb_read(gf_pkg::ADDR_RESULT, rdata, err);
		check_data("RESULT after busy reject", 8'h80, rdata[M-1:0]);
		apb_read(gf_pkg::ADDR_STATUS, status, err);
		check_flag("STATUS.empty", 1'b1, status[gf_pkg::STAT_EMPTY]);
		check_count("STATUS.count", 0, status[gf_pkg::STAT_COUNT +: CNT_W]);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule
